// File: dmr_top.f
+incdir+tb
logic/dmr_cfg_pkg.sv
logic/core_isa_pkg.sv
logic/cmd_fifo.sv
logic/lockstep_core.sv
logic/hmr_unit.sv
logic/dmr_top.sv
tb/tb_dmr_top.sv

// File: logic/cmd_fifo.sv
// Core command queue
`timescale 1ns/10ps

module cmd_fifo #(
    parameter int unsigned CMD_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  push_i,
    input  core_isa_pkg::opcode_t push_op_i,
    input  dmr_cfg_pkg::word_t    push_operand_i,
    input  logic                  pop_i,
    output logic                  empty_o,
    output core_isa_pkg::opcode_t head_op_o,
    output dmr_cfg_pkg::word_t    head_operand_o
);
    import dmr_cfg_pkg::*;
    import core_isa_pkg::*;

    localparam int unsigned PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(CMD_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    localparam ptr_t LAST_IDX = ptr_t'(CMD_DEPTH - 1);

    opcode_t op_mem      [CMD_DEPTH];
    word_t   operand_mem [CMD_DEPTH];
    ptr_t    wr_ptr_q;
    ptr_t    rd_ptr_q;
    cnt_t    count_q;

    // Wrap at the last entry, depth need not be a power of two
    function automatic ptr_t ptr_inc(ptr_t ptr);
        return (ptr == LAST_IDX) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            op_mem[wr_ptr_q]      <= push_op_i;
            operand_mem[wr_ptr_q] <= push_operand_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop_i)  rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head is read straight from the array
    assign empty_o        = (count_q == '0);
    assign head_op_o      = op_mem[rd_ptr_q];
    assign head_operand_o = operand_mem[rd_ptr_q];

endmodule

// File: logic/core_isa_pkg.sv
// Accumulator core command set
package core_isa_pkg;

    localparam int unsigned OP_WIDTH    = 2;
    localparam int unsigned SHAMT_WIDTH = 5;

    // Operation applied to the accumulator
    typedef enum logic [OP_WIDTH-1:0] {
        OP_LOAD = 2'd0,
        OP_ADD  = 2'd1,
        OP_XOR  = 2'd2,
        OP_ROTL = 2'd3
    } opcode_t;

    // Rotate amount, low bits of the operand
    typedef logic [SHAMT_WIDTH-1:0] shamt_t;

endpackage

// File: logic/dmr_cfg_pkg.sv
// Lockstep subsystem configuration
package dmr_cfg_pkg;

    // Operand and result word
    localparam int unsigned WORD_WIDTH = 32;

    // Two cores, one system port each
    localparam int unsigned NUM_CORES = 2;

    // Core roles in lockstep mode
    localparam int unsigned LEAD_CORE   = 0;
    localparam int unsigned SHADOW_CORE = 1;

    typedef logic [WORD_WIDTH-1:0] word_t;

    // One bit per core or port
    typedef logic [NUM_CORES-1:0] core_vec_t;

endpackage

// File: logic/dmr_top.sv
// Dual-core lockstep subsystem
`timescale 1ns/10ps

module dmr_top #(
    parameter int unsigned CMD_DEPTH   = 4,
    parameter int unsigned OUT_CREDITS = 2
) (
    input  logic                                               clk_i,
    input  logic                                               rst_n_i,
    input  logic                                               dmr_mode_i,
    // Command ports
    input  dmr_cfg_pkg::core_vec_t                             cmd_valid_i,
    input  core_isa_pkg::opcode_t [dmr_cfg_pkg::NUM_CORES-1:0] cmd_op_i,
    input  dmr_cfg_pkg::word_t    [dmr_cfg_pkg::NUM_CORES-1:0] cmd_operand_i,
    output dmr_cfg_pkg::core_vec_t                             cmd_credit_o,
    // Result ports
    output dmr_cfg_pkg::core_vec_t                             res_valid_o,
    output dmr_cfg_pkg::word_t    [dmr_cfg_pkg::NUM_CORES-1:0] res_data_o,
    input  dmr_cfg_pkg::core_vec_t                             res_credit_i,
    output logic                                               dmr_failure_o
);
    import dmr_cfg_pkg::*;
    import core_isa_pkg::*;

    // Between redundancy unit and cores
    core_vec_t                    core_cmd_valid;
    opcode_t   [NUM_CORES-1:0]    core_cmd_op;
    word_t     [NUM_CORES-1:0]    core_cmd_operand;
    core_vec_t                    core_cmd_credit;
    core_vec_t                    core_res_valid;
    word_t     [NUM_CORES-1:0]    core_res_data;
    core_vec_t                    core_res_credit;

    for (genvar i = 0; i < NUM_CORES; i++) begin : gen_core
        lockstep_core #(
            .CMD_DEPTH  (CMD_DEPTH),
            .OUT_CREDITS(OUT_CREDITS)
        ) i_lockstep_core (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .cmd_valid_i  (core_cmd_valid[i]),
            .cmd_op_i     (core_cmd_op[i]),
            .cmd_operand_i(core_cmd_operand[i]),
            .cmd_credit_o (core_cmd_credit[i]),
            .res_valid_o  (core_res_valid[i]),
            .res_data_o   (core_res_data[i]),
            .res_credit_i (core_res_credit[i])
        );
    end

    hmr_unit i_hmr_unit (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .dmr_mode_i        (dmr_mode_i),
        .sys_cmd_valid_i   (cmd_valid_i),
        .sys_cmd_op_i      (cmd_op_i),
        .sys_cmd_operand_i (cmd_operand_i),
        .sys_cmd_credit_o  (cmd_credit_o),
        .sys_res_valid_o   (res_valid_o),
        .sys_res_data_o    (res_data_o),
        .sys_res_credit_i  (res_credit_i),
        .core_cmd_valid_o  (core_cmd_valid),
        .core_cmd_op_o     (core_cmd_op),
        .core_cmd_operand_o(core_cmd_operand),
        .core_cmd_credit_i (core_cmd_credit),
        .core_res_valid_i  (core_res_valid),
        .core_res_data_i   (core_res_data),
        .core_res_credit_o (core_res_credit),
        .dmr_failure_o     (dmr_failure_o)
    );

endmodule

// File: logic/hmr_unit.sv
// Redundancy unit for two cores
`timescale 1ns/10ps

module hmr_unit (
    input  logic                                                  clk_i,
    input  logic                                                  rst_n_i,
    // 1 for lockstep, 0 for independent
    input  logic                                                  dmr_mode_i,
    // System side
    input  dmr_cfg_pkg::core_vec_t                                sys_cmd_valid_i,
    input  core_isa_pkg::opcode_t [dmr_cfg_pkg::NUM_CORES-1:0]    sys_cmd_op_i,
    input  dmr_cfg_pkg::word_t    [dmr_cfg_pkg::NUM_CORES-1:0]    sys_cmd_operand_i,
    output dmr_cfg_pkg::core_vec_t                                sys_cmd_credit_o,
    output dmr_cfg_pkg::core_vec_t                                sys_res_valid_o,
    output dmr_cfg_pkg::word_t    [dmr_cfg_pkg::NUM_CORES-1:0]    sys_res_data_o,
    input  dmr_cfg_pkg::core_vec_t                                sys_res_credit_i,
    // Core side
    output dmr_cfg_pkg::core_vec_t                                core_cmd_valid_o,
    output core_isa_pkg::opcode_t [dmr_cfg_pkg::NUM_CORES-1:0]    core_cmd_op_o,
    output dmr_cfg_pkg::word_t    [dmr_cfg_pkg::NUM_CORES-1:0]    core_cmd_operand_o,
    input  dmr_cfg_pkg::core_vec_t                                core_cmd_credit_i,
    input  dmr_cfg_pkg::core_vec_t                                core_res_valid_i,
    input  dmr_cfg_pkg::word_t    [dmr_cfg_pkg::NUM_CORES-1:0]    core_res_data_i,
    output dmr_cfg_pkg::core_vec_t                                core_res_credit_o,
    // Sticky mismatch flag
    output logic                                                  dmr_failure_o
);
    import dmr_cfg_pkg::*;

    logic mismatch;
    logic failure_q;

    // Steering per core
    always_comb begin
        for (int i = 0; i < NUM_CORES; i++) begin
            if (dmr_mode_i && (i != LEAD_CORE)) begin
                // Shadow core follows the lead port
                core_cmd_valid_o[i]   = sys_cmd_valid_i[LEAD_CORE];
                core_cmd_op_o[i]      = sys_cmd_op_i[LEAD_CORE];
                core_cmd_operand_o[i] = sys_cmd_operand_i[LEAD_CORE];
                core_res_credit_o[i]  = sys_res_credit_i[LEAD_CORE];
                // Its own port goes quiet
                sys_cmd_credit_o[i]   = 1'b0;
                sys_res_valid_o[i]    = 1'b0;
            end else begin
                core_cmd_valid_o[i]   = sys_cmd_valid_i[i];
                core_cmd_op_o[i]      = sys_cmd_op_i[i];
                core_cmd_operand_o[i] = sys_cmd_operand_i[i];
                core_res_credit_o[i]  = sys_res_credit_i[i];
                sys_cmd_credit_o[i]   = core_cmd_credit_i[i];
                sys_res_valid_o[i]    = core_res_valid_i[i];
            end
            sys_res_data_o[i] = core_res_data_i[i];
        end
    end

    // Data only matters while a result is emitted
    assign mismatch = dmr_mode_i &&
                      ((core_res_valid_i[LEAD_CORE] != core_res_valid_i[SHADOW_CORE]) ||
                       (core_res_valid_i[LEAD_CORE] &&
                        (core_res_data_i[LEAD_CORE] != core_res_data_i[SHADOW_CORE])));

    // Held until reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            failure_q <= 1'b0;
        end else if (mismatch) begin
            failure_q <= 1'b1;
        end
    end

    assign dmr_failure_o = failure_q;

endmodule

// File: logic/lockstep_core.sv
// Accumulator core with credit flow control
`timescale 1ns/10ps

module lockstep_core #(
    parameter int unsigned CMD_DEPTH   = 4,
    parameter int unsigned OUT_CREDITS = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // Command channel
    input  logic                  cmd_valid_i,
    input  core_isa_pkg::opcode_t cmd_op_i,
    input  dmr_cfg_pkg::word_t    cmd_operand_i,
    output logic                  cmd_credit_o,
    // Result channel
    output logic                  res_valid_o,
    output dmr_cfg_pkg::word_t    res_data_o,
    input  logic                  res_credit_i
);
    import dmr_cfg_pkg::*;
    import core_isa_pkg::*;

    localparam int unsigned CRED_W = $clog2(OUT_CREDITS + 1);

    typedef logic [CRED_W-1:0] credit_t;

    logic                    fifo_empty;
    opcode_t                 head_op;
    word_t                   head_operand;
    logic                    pop;
    credit_t                 credit_q;
    word_t                   acc_q;
    word_t                   acc_next;
    shamt_t                  shamt;
    logic [2*WORD_WIDTH-1:0] rot_dbl;

    cmd_fifo #(
        .CMD_DEPTH(CMD_DEPTH)
    ) i_cmd_fifo (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .push_i        (cmd_valid_i),
        .push_op_i     (cmd_op_i),
        .push_operand_i(cmd_operand_i),
        .pop_i         (pop),
        .empty_o       (fifo_empty),
        .head_op_o     (head_op),
        .head_operand_o(head_operand)
    );

    // Only execute when the result has somewhere to go
    assign pop = !fifo_empty && (credit_q != '0);

    // Rotate via a doubled word, upper half holds the result
    assign shamt   = shamt_t'(head_operand);
    assign rot_dbl = {acc_q, acc_q} << shamt;

    always_comb begin
        unique case (head_op)
            OP_LOAD: acc_next = head_operand;
            OP_ADD:  acc_next = acc_q + head_operand;
            OP_XOR:  acc_next = acc_q ^ head_operand;
            OP_ROTL: acc_next = rot_dbl[2*WORD_WIDTH-1 -: WORD_WIDTH];
            default: acc_next = acc_q;
        endcase
    end

    // The accumulator doubles as the result register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_q        <= '0;
            res_valid_o  <= 1'b0;
            cmd_credit_o <= 1'b0;
        end else begin
            if (pop) acc_q <= acc_next;
            res_valid_o  <= pop;
            cmd_credit_o <= pop;
        end
    end

    // Result credits, spent at pop and refilled by the consumer
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_q <= credit_t'(OUT_CREDITS);
        end else begin
            case ({pop, res_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    assign res_data_o = acc_q;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the lockstep subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
log_file=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_dmr_top -f dmr_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dmr_top > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF 'All tests passed!' "$log_file"; then
    exit 0
fi
echo "Pass message not found in $log_file"
exit 1

// File: tb/dmr_ref_model.svh
// Accumulator reference model
`ifndef DMR_REF_MODEL_SVH
`define DMR_REF_MODEL_SVH

// Run length and seed
localparam int unsigned SEED_VALUE   = 32'h98aa033b;
localparam int          RESET_CYCLES = 10;
localparam int          N_IND        = 24;
localparam int          N_LS         = 24;
localparam int          N_DIV        = 8;
localparam int          HOLD_CYCLES  = 20;

// Expected accumulator after one command
function automatic word_t ref_apply(word_t acc, opcode_t op, word_t operand);
    word_t       r;
    int unsigned n;
    r = acc;
    n = int'(operand[4:0]);
    case (op)
        OP_LOAD: r = operand;
        OP_ADD:  r = acc + operand;
        OP_XOR:  r = acc ^ operand;
        default: begin
            // One bit per step
            for (int unsigned i = 0; i < n; i++) begin
                r = {r[WORD_WIDTH-2:0], r[WORD_WIDTH-1]};
            end
        end
    endcase
    return r;
endfunction

`endif

// File: tb/tb_dmr_top.sv
// Lockstep subsystem testbench
`timescale 1ns/10ps

module tb_dmr_top;
    import dmr_cfg_pkg::*;
    import core_isa_pkg::*;

    localparam int CMD_DEPTH   = 4;
    localparam int OUT_CREDITS = 2;

    `include "dmr_ref_model.svh"

    localparam int BP_CMDS        = CMD_DEPTH + OUT_CREDITS;
    localparam int TOTAL_CMDS     = 2 * N_IND + BP_CMDS + 1 + N_LS + 3 * N_DIV + 2;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 20 * TOTAL_CMDS;

    logic                     clk_i;
    logic                     rst_n_i;
    logic                     dmr_mode_i;
    core_vec_t                cmd_valid_i;
    opcode_t   [NUM_CORES-1:0] cmd_op_i;
    word_t     [NUM_CORES-1:0] cmd_operand_i;
    core_vec_t                cmd_credit_o;
    core_vec_t                res_valid_o;
    word_t     [NUM_CORES-1:0] res_data_o;
    core_vec_t                res_credit_i;
    logic                     dmr_failure_o;

    // Model state and bookkeeping per port
    word_t exp_q [NUM_CORES][$];
    word_t model_acc [NUM_CORES];
    int    send_credit [NUM_CORES];
    int    pending_ret [NUM_CORES];
    int    res_count [NUM_CORES];
    int    credit_pulses [NUM_CORES];
    logic  hold_credits;
    logic  expect_fail;
    int    cycle_cnt;
    int    check_cnt;
    int    err_cnt;
    string test_name;

    dmr_top #(
        .CMD_DEPTH  (CMD_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) i_dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .dmr_mode_i   (dmr_mode_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_op_i     (cmd_op_i),
        .cmd_operand_i(cmd_operand_i),
        .cmd_credit_o (cmd_credit_o),
        .res_valid_o  (res_valid_o),
        .res_data_o   (res_data_o),
        .res_credit_i (res_credit_i),
        .dmr_failure_o(dmr_failure_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            err_cnt++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    // Drive one command and predict its result
    task automatic issue_cmd(int p, opcode_t op, word_t operand);
        cmd_valid_i[p]   <= 1'b1;
        cmd_op_i[p]      <= op;
        cmd_operand_i[p] <= operand;
        send_credit[p]--;
        model_acc[p] = ref_apply(model_acc[p], op, operand);
        exp_q[p].push_back(model_acc[p]);
        if (dmr_mode_i && p == 0) begin
            // Shadow core sees the same command
            model_acc[1] = ref_apply(model_acc[1], op, operand);
            if (model_acc[1] != model_acc[0]) expect_fail = 1'b1;
        end
    endtask

    task automatic send_one(int p, opcode_t op, word_t operand);
        @(posedge clk_i);
        while (send_credit[p] == 0) @(posedge clk_i);
        issue_cmd(p, op, operand);
        @(posedge clk_i);
        cmd_valid_i[p] <= 1'b0;
    endtask

    // Random commands on port 0, or on both ports
    task automatic run_stream(int n, logic both);
        int sent [NUM_CORES];
        sent = '{default: 0};
        while (sent[0] < n || (both && sent[1] < n)) begin
            @(posedge clk_i);
            for (int p = 0; p < NUM_CORES; p++) begin
                if ((p == 0 || both) && sent[p] < n && send_credit[p] > 0 &&
                    $urandom_range(0, 3) != 0) begin
                    issue_cmd(p, opcode_t'($urandom_range(0, 3)), $urandom());
                    sent[p]++;
                end else begin
                    cmd_valid_i[p] <= 1'b0;
                end
            end
        end
        @(posedge clk_i);
        cmd_valid_i <= '0;
    endtask

    // Idle once every result is seen and its credit returned
    task automatic wait_drain();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0 || pending_ret[0] != 0 ||
               pending_ret[1] != 0)
            @(posedge clk_i);
        repeat (2) @(negedge clk_i);
    endtask

    // Result and credit monitor
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            for (int p = 0; p < NUM_CORES; p++) begin
                if (cmd_credit_o[p]) begin
                    send_credit[p]++;
                    credit_pulses[p]++;
                end
                if (res_valid_o[p]) begin
                    res_count[p]++;
                    pending_ret[p]++;
                    if (exp_q[p].size() == 0) begin
                        err_cnt++;
                        $display("%s: port %0d gave a result with no command outstanding",
                                 test_name, p);
                    end else begin
                        check_value($sformatf("port %0d result", p), exp_q[p].pop_front(),
                                    res_data_o[p]);
                    end
                end
            end
            if (dmr_mode_i && (res_valid_o[1] || cmd_credit_o[1])) begin
                err_cnt++;
                $display("%s: port 1 was active in lockstep mode", test_name);
            end
        end
    end

    // Random result credit return
    always @(posedge clk_i) begin
        for (int p = 0; p < NUM_CORES; p++) begin
            if (!hold_credits && pending_ret[p] > 0 && $urandom_range(0, 1) == 1) begin
                res_credit_i[p] <= 1'b1;
                pending_ret[p]--;
            end else begin
                res_credit_i[p] <= 1'b0;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout in %s after %0d cycles with %0d errors", test_name, cycle_cnt,
                     err_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED_VALUE));
        rst_n_i       <= 1'b0;
        dmr_mode_i    <= 1'b0;
        cmd_valid_i   <= '0;
        cmd_op_i      <= '{default: OP_LOAD};
        cmd_operand_i <= '0;
        res_credit_i  <= '0;
        for (int p = 0; p < NUM_CORES; p++) begin
            model_acc[p]     = '0;
            send_credit[p]   = CMD_DEPTH;
            pending_ret[p]   = 0;
            res_count[p]     = 0;
            credit_pulses[p] = 0;
        end
        hold_credits = 1'b0;
        expect_fail  = 1'b0;
        cycle_cnt    = 0;
        check_cnt    = 0;
        err_cnt      = 0;
        test_name    = "reset";
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (2) begin
            @(negedge clk_i);
            check_value("res_valid", '0, 32'(res_valid_o));
            check_value("cmd_credit", '0, 32'(cmd_credit_o));
            check_value("dmr_failure", '0, 32'(dmr_failure_o));
        end

        test_name = "independent";
        run_stream(N_IND, 1'b1);
        wait_drain();

        test_name = "backpressure";
        hold_credits     = 1'b1;
        res_count[0]     = 0;
        credit_pulses[0] = 0;
        run_stream(BP_CMDS, 1'b0);
        repeat (HOLD_CYCLES) @(negedge clk_i);
        check_value("held results", OUT_CREDITS, res_count[0]);
        hold_credits = 1'b0;
        wait_drain();
        check_value("command credits", BP_CMDS, credit_pulses[0]);

        test_name = "lockstep_match";
        @(posedge clk_i);
        dmr_mode_i <= 1'b1;
        send_one(0, OP_LOAD, $urandom());
        run_stream(N_LS, 1'b0);
        wait_drain();
        check_value("dmr_failure", 32'(expect_fail), 32'(dmr_failure_o));

        test_name = "lockstep_diverge";
        @(posedge clk_i);
        dmr_mode_i <= 1'b0;
        run_stream(N_DIV, 1'b1);
        if (model_acc[0] == model_acc[1]) send_one(1, OP_XOR, 32'h1);
        wait_drain();
        @(posedge clk_i);
        dmr_mode_i <= 1'b1;
        send_one(0, OP_ADD, $urandom());
        wait_drain();
        check_value("dmr_failure first", 32'(expect_fail), 32'(dmr_failure_o));
        run_stream(N_DIV, 1'b0);
        wait_drain();
        check_value("dmr_failure held", 32'(expect_fail), 32'(dmr_failure_o));

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
